// ==== hw/cp0.sv ====
`include "cp0_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module cp0 (
	input  wire                     clk,
	input  wire                     rst,
	input  wire cp0_pkg::reg_addr_t raddr1,
	input  wire cp0_pkg::reg_addr_t raddr2,
	input  wire [2:0]               rsel1,
	input  wire [2:0]               rsel2,
	input  wire                     we,
	input  wire cp0_pkg::reg_addr_t waddr,
	input  wire cp0_pkg::word_t     wdata,
	input  wire cp0_pkg::word_t     wmask,
	input  wire                     exc_flush,
	input  wire                     exc_eret,
	input  wire                     exc_delayslot,
	input  wire [4:0]               exc_code,
	input  wire cp0_pkg::word_t     exc_extra,
	input  wire cp0_pkg::word_t     exc_pc,
	input  wire [5:0]               int_req,
	output cp0_pkg::word_t          rdata1,
	output cp0_pkg::word_t          rdata2,
	output cp0_pkg::cp0_regs_t      regs
);

	cp0_pkg::cp0_regs_t regs_q;
	cp0_pkg::cp0_regs_t regs_d;
	cp0_pkg::word_t     cur_word;

	function automatic cp0_pkg::word_t read_word(
		input cp0_pkg::cp0_regs_t r,
		input cp0_pkg::reg_addr_t a,
		input logic [2:0]         s
	);
		if (s != 3'd0)
			return `ZERO_WORD;
		return r[a * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];
	endfunction

	// reads see the next-state word, so same-cycle updates bypass
	assign rdata1 = read_word(regs_d, raddr1, rsel1);
	assign rdata2 = read_word(regs_d, raddr2, rsel2);
	assign regs   = regs_q;

	always_comb
	begin
		regs_d           = '0; // unused numbers read as zero
		regs_d.bad_vaddr = regs_q.bad_vaddr;
		regs_d.status    = regs_q.status;
		regs_d.cause     = regs_q.cause;
		regs_d.epc       = regs_q.epc;
		regs_d.count     = regs_q.count + 32'd1;

		regs_d.cause.ip[7:2] = int_req; // sampled every clock

		// mtc0 from write-back
		cur_word = regs_d[waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH];
		if (we)
		begin
			regs_d[waddr * `REG_DATA_WIDTH +: `REG_DATA_WIDTH] =
				(wdata & wmask) | (cur_word & ~wmask);
		end

		// exception or eret from memory stage
		if (exc_flush)
		begin
			if (exc_eret)
			begin
				if (regs_d.status.erl)
					regs_d.status.erl = 1'b0;
				else
					regs_d.status.exl = 1'b0;
			end
			else
			begin
				if (!regs_d.status.exl) // nested exceptions keep epc
				begin
					if (exc_delayslot)
					begin
						regs_d.epc      = exc_pc - 32'd4;
						regs_d.cause.bd = 1'b1;
					end
					else
					begin
						regs_d.epc      = exc_pc;
						regs_d.cause.bd = 1'b0;
					end
				end

				regs_d.status.exl     = 1'b1;
				regs_d.cause.ce       = exc_extra[1:0];
				regs_d.cause.exc_code = exc_code;

				if (exc_code == `EXCCODE_ADEL || exc_code == `EXCCODE_ADES)
					regs_d.bad_vaddr = exc_extra;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regs_q.count  <= `ZERO_WORD;
			regs_q.cause  <= `ZERO_WORD;
			regs_q.status <= `STATUS_RESET;
		end
		else
		begin
			regs_q <= regs_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/cp0_except_arbiter.sv ====
`include "cp0_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module cp0_except_arbiter (
	input  wire cp0_pkg::word_t   pc,
	input  wire cp0_pkg::word_t   bad_addr,
	input  wire                   in_delayslot,
	input  wire                   adel_fetch,
	input  wire                   ri,
	input  wire                   ov,
	input  wire                   syscall,
	input  wire                   brk,
	input  wire                   adel_data,
	input  wire                   ades_data,
	input  wire                   eret,
	input  wire cp0_pkg::status_t status,
	input  wire cp0_pkg::cause_t  cause,
	input  wire cp0_pkg::word_t   epc,
	output logic                  exc_flush,
	output logic                  exc_eret,
	output logic                  exc_delayslot,
	output logic [4:0]            exc_code,
	output cp0_pkg::word_t        exc_extra,
	output cp0_pkg::word_t        exc_pc,
	output cp0_pkg::word_t        redirect_pc
);

	logic int_pending;
	logic exc_any;

	// registered ip, so a new line is seen one clock late
	assign int_pending = status.ie & ~status.exl & ~status.erl & (|(cause.ip & status.im));

	always_comb
	begin
		exc_any   = 1'b1;
		exc_code  = `EXCCODE_INT;
		exc_extra = `ZERO_WORD;
		if (int_pending)
			exc_code = `EXCCODE_INT;
		else if (adel_fetch)
		begin
			exc_code  = `EXCCODE_ADEL;
			exc_extra = pc; // fetch from bad pc
		end
		else if (ri)
			exc_code = `EXCCODE_RI;
		else if (ov)
			exc_code = `EXCCODE_OV;
		else if (syscall)
			exc_code = `EXCCODE_SYS;
		else if (brk)
			exc_code = `EXCCODE_BP;
		else if (adel_data)
		begin
			exc_code  = `EXCCODE_ADEL;
			exc_extra = bad_addr;
		end
		else if (ades_data)
		begin
			exc_code  = `EXCCODE_ADES;
			exc_extra = bad_addr;
		end
		else
			exc_any = 1'b0;
	end

	assign exc_eret      = eret & ~exc_any; // eret loses to any exception
	assign exc_flush     = exc_any | eret;
	assign exc_delayslot = in_delayslot;
	assign exc_pc        = pc;

	assign redirect_pc = exc_eret ? epc : (status.bev ? `VEC_BOOT : `VEC_NORMAL);

endmodule

`default_nettype wire

// ==== hw/cp0_pkg.sv ====
`include "cp0_settings.svh"
`default_nettype none

package cp0_pkg;

	typedef logic [`REG_DATA_WIDTH-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		logic [3:0] cu; // cu[0] is cp0 usable
		logic [4:0] zero_27_23;
		logic       bev; // boot exception vectors
		logic [5:0] zero_21_16;
		logic [7:0] im; // interrupt mask
		logic [4:0] zero_7_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic        bd; // exception in delay slot
		logic        zero_30;
		logic [1:0]  ce;
		logic [11:0] zero_27_16;
		logic [7:0]  ip; // ip[7:2] follow the int lines
		logic        zero_7;
		logic [4:0]  exc_code;
		logic [1:0]  zero_1_0;
	} cause_t;

	// Word i of the packed vector is cp0 register i, so the whole struct
	// can be indexed by register number as well as reached by field name.
	typedef struct packed {
		word_t [31:15] reg_31_15;
		word_t         epc; // 14
		cause_t        cause; // 13
		status_t       status; // 12
		word_t [11:10] reg_11_10;
		word_t         count; // 9
		word_t         bad_vaddr; // 8
		word_t [7:0]   reg_7_0;
	} cp0_regs_t;

endpackage

`default_nettype wire

// ==== hw/cp0_unit.sv ====
`include "cp0_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module cp0_unit (
	input  wire                     clk,
	input  wire                     rst,
	input  wire cp0_pkg::reg_addr_t raddr1,
	input  wire [2:0]               rsel1,
	input  wire cp0_pkg::reg_addr_t raddr2,
	input  wire [2:0]               rsel2,
	input  wire                     we,
	input  wire cp0_pkg::reg_addr_t waddr,
	input  wire [2:0]               wsel,
	input  wire cp0_pkg::word_t     wdata,
	input  wire cp0_pkg::word_t     pc,
	input  wire                     in_delayslot,
	input  wire                     adel_fetch,
	input  wire                     ri,
	input  wire                     ov,
	input  wire                     syscall,
	input  wire                     brk,
	input  wire                     adel_data,
	input  wire                     ades_data,
	input  wire cp0_pkg::word_t     bad_addr,
	input  wire                     eret,
	input  wire [5:0]               int_req,
	output wire cp0_pkg::word_t     rdata1,
	output wire cp0_pkg::word_t     rdata2,
	output wire                     flush,
	output wire cp0_pkg::word_t     redirect_pc,
	output wire cp0_pkg::status_t   status,
	output wire cp0_pkg::cause_t    cause,
	output wire cp0_pkg::word_t     epc,
	output wire cp0_pkg::word_t     count
);

	wire cp0_pkg::word_t     wmask;
	wire cp0_pkg::cp0_regs_t regs;
	wire                     exc_eret;
	wire                     exc_delayslot;
	wire [4:0]               exc_code;
	wire cp0_pkg::word_t     exc_extra;
	wire cp0_pkg::word_t     exc_pc;

	assign status = regs.status;
	assign cause  = regs.cause;
	assign epc    = regs.epc;
	assign count  = regs.count;

	cp0_write_mask u_write_mask (
		.sel  (wsel),
		.addr (waddr),
		.mask (wmask)
	);

	cp0_except_arbiter u_arbiter (
		.pc            (pc),
		.bad_addr      (bad_addr),
		.in_delayslot  (in_delayslot),
		.adel_fetch    (adel_fetch),
		.ri            (ri),
		.ov            (ov),
		.syscall       (syscall),
		.brk           (brk),
		.adel_data     (adel_data),
		.ades_data     (ades_data),
		.eret          (eret),
		.status        (regs.status),
		.cause         (regs.cause),
		.epc           (regs.epc),
		.exc_flush     (flush),
		.exc_eret      (exc_eret),
		.exc_delayslot (exc_delayslot),
		.exc_code      (exc_code),
		.exc_extra     (exc_extra),
		.exc_pc        (exc_pc),
		.redirect_pc   (redirect_pc)
	);

	cp0 u_cp0 (
		.clk           (clk),
		.rst           (rst),
		.raddr1        (raddr1),
		.raddr2        (raddr2),
		.rsel1         (rsel1),
		.rsel2         (rsel2),
		.we            (we),
		.waddr         (waddr),
		.wdata         (wdata),
		.wmask         (wmask),
		.exc_flush     (flush),
		.exc_eret      (exc_eret),
		.exc_delayslot (exc_delayslot),
		.exc_code      (exc_code),
		.exc_extra     (exc_extra),
		.exc_pc        (exc_pc),
		.int_req       (int_req),
		.rdata1        (rdata1),
		.rdata2        (rdata2),
		.regs          (regs)
	);

endmodule

`default_nettype wire

// ==== hw/cp0_write_mask.sv ====
`include "cp0_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module cp0_write_mask (
	input  wire [2:0]              sel,
	input  wire cp0_pkg::reg_addr_t addr,
	output cp0_pkg::word_t          mask
);

	localparam cp0_pkg::word_t MASK_ALL    = 32'hFFFF_FFFF;
	localparam cp0_pkg::word_t MASK_STATUS = 32'h1040_FF07; // cu0 bev im erl exl ie
	localparam cp0_pkg::word_t MASK_CAUSE  = 32'h0000_0300; // ip[1:0]

	always_comb
	begin
		mask = `ZERO_WORD;
		if (sel == 3'd0)
		begin
			case (addr)
				`REG_COUNT:
				begin
					mask = MASK_ALL;
				end
				`REG_EPC:
				begin
					mask = MASK_ALL;
				end
				`REG_STATUS:
				begin
					mask = MASK_STATUS;
				end
				`REG_CAUSE:
				begin
					mask = MASK_CAUSE;
				end
				default:
				begin
					mask = `ZERO_WORD; // badvaddr and unused numbers
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== include/cp0_settings.svh ====
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

`define REG_DATA_WIDTH 32
`define ZERO_WORD      32'h0000_0000

// cp0 register numbers
`define REG_BADVADDR 5'd8
`define REG_COUNT    5'd9
`define REG_STATUS   5'd12
`define REG_CAUSE    5'd13
`define REG_EPC      5'd14

// cause.exc_code values
`define EXCCODE_INT  5'd0
`define EXCCODE_ADEL 5'd4
`define EXCCODE_ADES 5'd5
`define EXCCODE_SYS  5'd8
`define EXCCODE_BP   5'd9
`define EXCCODE_RI   5'd10
`define EXCCODE_OV   5'd12

`define STATUS_RESET 32'h1040_0000 // cu0 and bev

// handler entry points
`define VEC_BOOT   32'hBFC0_0380
`define VEC_NORMAL 32'h8000_0180

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build the cp0 testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module cp0_tb \
	-f verilog.f -o cp0_sim || exit 1
result=$(./obj_dir/cp0_sim)
echo "$result"
echo "$result" | grep -q "^TESTBENCH PASSED$" && echo "simulation passed" || exit 1

// ==== verif/cp0_tb.sv ====
`include "cp0_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

	localparam int PERIOD = 10;
	localparam int WRITE_CYCLES = 60;
	// reset, then reset test, mtc0, exceptions, nested, eret, interrupts
	localparam int TEST_CYCLES = 2 + 7 + (WRITE_CYCLES + 4) + 27 + 4 + 6 + 31;
	localparam int MARGIN = 100;
	localparam cp0_pkg::word_t STATUS_WR = 32'h1040_FF07; // cu0 bev im erl exl ie
	localparam cp0_pkg::word_t CAUSE_WR = 32'h0000_0300; // ip[1:0]
	localparam cp0_pkg::word_t STATUS_QUIET = 32'h1000_0000; // cu0 only

	typedef struct packed {
		logic               we;
		cp0_pkg::reg_addr_t waddr;
		logic [2:0]         wsel;
		cp0_pkg::word_t     wdata;
		cp0_pkg::word_t     pc;
		logic               in_delayslot;
		logic [6:0]         flags; // adel_fetch first, ades_data last
		cp0_pkg::word_t     bad_addr;
		logic               eret;
		logic [5:0]         int_req;
	} stim_t;

	typedef struct packed {
		cp0_pkg::word_t   bad_vaddr;
		cp0_pkg::word_t   count;
		cp0_pkg::status_t status;
		cp0_pkg::cause_t  cause;
		cp0_pkg::word_t   epc;
		logic             bv_known; // badvaddr and epc start undefined
		logic             epc_known;
	} model_t;

	typedef struct packed {
		logic           flush;
		logic           eret;
		logic [4:0]     code;
		cp0_pkg::word_t extra;
		cp0_pkg::word_t redirect;
	} arb_t;

	logic clk;
	logic rst;
	cp0_pkg::reg_addr_t raddr1, raddr2, waddr;
	logic [2:0] rsel1, rsel2, wsel;
	logic we, in_delayslot, eret;
	logic adel_fetch, ri, ov, syscall, brk, adel_data, ades_data;
	cp0_pkg::word_t wdata, pc, bad_addr;
	logic [5:0] int_req;
	cp0_pkg::word_t rdata1, rdata2, redirect_pc, epc, count;
	logic flush;
	cp0_pkg::status_t status;
	cp0_pkg::cause_t cause;

	integer seed;
	int err_count;
	int test_count;
	int test_start_errs;
	model_t model_q;
	model_t model_d;
	stim_t stim_now;
	arb_t arb_now;

	cp0_unit uut (.*);

	function automatic arb_t arbitrate(input model_t m, input stim_t s);
		arb_t a;
		logic irq;
		a = '0;
		irq = m.status.ie & ~m.status.exl & ~m.status.erl & (|(m.cause.ip & m.status.im));
		casez ({irq, s.flags})
			8'b1???_????: a.code = `EXCCODE_INT;
			8'b01??_????: a.code = `EXCCODE_ADEL;
			8'b001?_????: a.code = `EXCCODE_RI;
			8'b0001_????: a.code = `EXCCODE_OV;
			8'b0000_1???: a.code = `EXCCODE_SYS;
			8'b0000_01??: a.code = `EXCCODE_BP;
			8'b0000_001?: a.code = `EXCCODE_ADEL;
			8'b0000_0001: a.code = `EXCCODE_ADES;
			default: a.eret = s.eret; // eret only without exception
		endcase
		a.flush = irq | (|s.flags) | s.eret;
		if (a.code == `EXCCODE_ADEL || a.code == `EXCCODE_ADES)
			a.extra = s.flags[6] ? s.pc : s.bad_addr;
		a.redirect = a.eret ? m.epc : (m.status.bev ? `VEC_BOOT : `VEC_NORMAL);
		return a;
	endfunction

	function automatic model_t model_step(input model_t m, input stim_t s);
		model_t n;
		arb_t a;
		n = m;
		a = arbitrate(m, s);
		n.count = m.count + 32'd1;
		n.cause.ip[7:2] = s.int_req;
		if (s.we && s.wsel == 3'd0)
		begin
			case (s.waddr)
				`REG_COUNT: n.count = s.wdata;
				`REG_STATUS: n.status = (s.wdata & STATUS_WR) | (n.status & ~STATUS_WR);
				`REG_CAUSE: n.cause = (s.wdata & CAUSE_WR) | (n.cause & ~CAUSE_WR);
				`REG_EPC:
				begin
					n.epc = s.wdata;
					n.epc_known = 1'b1;
				end
				default: ; // badvaddr is read only
			endcase
		end
		if (a.eret)
		begin
			if (n.status.erl)
				n.status.erl = 1'b0;
			else
				n.status.exl = 1'b0;
		end
		else if (a.flush)
		begin
			if (!n.status.exl)
			begin
				n.epc = s.in_delayslot ? s.pc - 32'd4 : s.pc;
				n.cause.bd = s.in_delayslot;
				n.epc_known = 1'b1;
			end
			n.status.exl = 1'b1;
			n.cause.ce = a.extra[1:0]; // low bits of the bad address
			n.cause.exc_code = a.code;
			if (a.code == `EXCCODE_ADEL || a.code == `EXCCODE_ADES)
			begin
				n.bad_vaddr = a.extra;
				n.bv_known = 1'b1;
			end
		end
		return n;
	endfunction

	function automatic cp0_pkg::word_t read_model(input model_t st,
		input cp0_pkg::reg_addr_t addr, input logic [2:0] sel);
		if (sel != 3'd0)
			return `ZERO_WORD;
		case (addr)
			`REG_BADVADDR: return st.bad_vaddr;
			`REG_COUNT: return st.count;
			`REG_STATUS: return st.status;
			`REG_CAUSE: return st.cause;
			`REG_EPC: return st.epc;
			default: return `ZERO_WORD;
		endcase
	endfunction

	function automatic logic read_defined(input model_t st,
		input cp0_pkg::reg_addr_t addr, input logic [2:0] sel);
		if (sel == 3'd0 && addr == `REG_BADVADDR)
			return st.bv_known;
		if (sel == 3'd0 && addr == `REG_EPC)
			return st.epc_known;
		return 1'b1;
	endfunction

	task automatic check_value(input string name, input cp0_pkg::word_t got,
		input cp0_pkg::word_t expected);
		if (got !== expected)
		begin
			err_count = err_count + 1;
			$display("error: %s is %h, expected %h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic idle_inputs();
		cp0_pkg::word_t r;
		r = $random(seed);
		we = 1'b0;
		waddr = r[4:0];
		wsel = 3'd0;
		wdata = $random(seed);
		raddr1 = r[9:5];
		rsel1 = 3'd0;
		raddr2 = r[14:10];
		rsel2 = r[15] ? r[18:16] : 3'd0;
		pc = $random(seed);
		bad_addr = $random(seed);
		in_delayslot = r[19];
		{adel_fetch, ri, ov, syscall, brk, adel_data, ades_data} = 7'd0;
		eret = 1'b0;
	endtask

	task automatic next_cycle();
		@(negedge clk);
		idle_inputs();
	endtask

	task automatic write_reg(input cp0_pkg::reg_addr_t addr, input cp0_pkg::word_t data);
		next_cycle();
		we = 1'b1;
		waddr = addr;
		wdata = data;
		raddr1 = addr; // merged value visible same cycle
	endtask

	task automatic raise_flags(input logic [6:0] f);
		next_cycle();
		{adel_fetch, ri, ov, syscall, brk, adel_data, ades_data} = f;
		raddr1 = `REG_EPC;
		raddr2 = `REG_BADVADDR;
		rsel2 = 3'd0;
	endtask

	task automatic try_interrupt(input cp0_pkg::word_t st);
		write_reg(`REG_STATUS, st);
		next_cycle();
		int_req = 6'b00_0100; // line 2 lands on ip4
		repeat (3)
			next_cycle();
		int_req = 6'd0;
		write_reg(`REG_STATUS, STATUS_QUIET);
	endtask

	task automatic end_test(input string name);
		next_cycle();
		$display("test %s done, %0d errors", name, err_count - test_start_errs);
		test_start_errs = err_count;
		test_count = test_count + 1;
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			model_q = '0;
			model_q.status = `STATUS_RESET;
		end
		else
		begin
			stim_now = {we, waddr, wsel, wdata, pc, in_delayslot, adel_fetch, ri, ov,
				syscall, brk, adel_data, ades_data, bad_addr, eret, int_req};
			arb_now = arbitrate(model_q, stim_now);
			model_d = model_step(model_q, stim_now);
			check_value("status", status, model_q.status);
			check_value("cause", cause, model_q.cause);
			check_value("count", count, model_q.count);
			if (model_q.epc_known)
				check_value("epc", epc, model_q.epc);
			check_value("flush", {31'd0, flush}, {31'd0, arb_now.flush});
			if (!arb_now.eret || model_q.epc_known)
				check_value("redirect_pc", redirect_pc, arb_now.redirect);
			if (read_defined(model_d, raddr1, rsel1))
				check_value("rdata1", rdata1, read_model(model_d, raddr1, rsel1));
			if (read_defined(model_d, raddr2, rsel2))
				check_value("rdata2", rdata2, read_model(model_d, raddr2, rsel2));
			model_q = model_d;
		end
	end

	initial
	begin
		#(PERIOD * (TEST_CYCLES + MARGIN));
		$display("timeout: tests still running after %0d cycles", TEST_CYCLES + MARGIN);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		int i;
		cp0_pkg::word_t r;
		seed = 32'h480f52f0;
		err_count = 0;
		test_count = 0;
		test_start_errs = 0;
		rst = 1'b1;
		int_req = 6'd0;
		idle_inputs();
		repeat (2)
			@(negedge clk);
		rst = 1'b0;
		raddr1 = `REG_COUNT; // first read after reset gives 1
		rsel1 = 3'd0;
		raddr2 = `REG_CAUSE;
		rsel2 = 3'd0;

		repeat (6)
			next_cycle();
		end_test("reset");

		repeat (WRITE_CYCLES)
		begin
			next_cycle();
			r = $random(seed);
			we = 1'b1;
			wsel = (r[3:0] == 4'd0) ? r[6:4] : 3'd0;
			case (r[9:7])
				3'd0: waddr = `REG_BADVADDR;
				3'd1: waddr = `REG_COUNT;
				3'd2: waddr = `REG_STATUS;
				3'd3: waddr = `REG_CAUSE;
				3'd4: waddr = `REG_EPC;
				default: waddr = r[14:10];
			endcase
			raddr1 = waddr;
			rsel1 = wsel;
		end
		write_reg(`REG_STATUS, STATUS_QUIET); // bev off from here on
		write_reg(`REG_CAUSE, `ZERO_WORD);
		write_reg(`REG_STATUS, STATUS_QUIET);
		end_test("mtc0");

		for (i = 0; i < 7; i++)
		begin
			raise_flags(7'b100_0000 >> i);
			write_reg(`REG_STATUS, STATUS_QUIET); // clear exl
		end
		repeat (6)
		begin
			r = $random(seed);
			raise_flags(r[6:0]);
			eret = r[7];
			write_reg(`REG_STATUS, STATUS_QUIET);
		end
		end_test("exceptions");

		raise_flags(7'b000_1000); // syscall
		raise_flags(7'b001_0000); // ov with exl still set
		write_reg(`REG_STATUS, STATUS_QUIET);
		end_test("nested");

		raise_flags(7'b000_0100);
		next_cycle();
		eret = 1'b1;
		write_reg(`REG_STATUS, STATUS_QUIET | 32'h0000_0006); // erl and exl
		repeat (2)
		begin
			next_cycle();
			eret = 1'b1;
		end
		end_test("eret");

		try_interrupt(32'h1000_1001);
		try_interrupt(32'h1000_1000); // ie clear
		try_interrupt(32'h1000_2001); // im on another line
		try_interrupt(32'h1000_1003); // exl set
		try_interrupt(32'h1000_1005); // erl set
		end_test("interrupts");

		$display("%0d tests run, %0d errors", test_count, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/cp0_pkg.sv
hw/cp0_write_mask.sv
hw/cp0_except_arbiter.sv
hw/cp0.sv
hw/cp0_unit.sv
verif/cp0_tb.sv
